/* Bender.yml */
package:
  name: mem_subsys

sources:
  - files:
      - verilog/axi_mem_pkg.sv
      - verilog/sram_axi_slave.sv
      - verilog/axi_read_arbiter.sv
      - verilog/mem_subsys_top.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/mem_subsys_props.sv
      - tb/mem_subsys_tb.sv

/* compile.f */
verilog/axi_mem_pkg.sv
verilog/sram_axi_slave.sv
verilog/axi_read_arbiter.sv
verilog/mem_subsys_top.sv
tb/tb_clock_gen.sv
tb/mem_subsys_props.sv
tb/mem_subsys_tb.sv

/* tb/mem_subsys_props.sv */
`timescale 1ns/1ps

module mem_subsys_props (
	input logic                clk,
	input logic                rst,
	input logic                arready,
	input logic                rvalid,
	input logic                rready,
	input axi_mem_pkg::r_rsp_t r,
	input logic                bvalid,
	input logic                bready,
	input axi_mem_pkg::b_rsp_t b
);

	// bumped by every failing assertion below
	int fail_cnt = 0;

	// read response held and frozen until rready
	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(r))
		else begin
			$error("read response dropped or changed before its handshake");
			fail_cnt++;
		end

	// write response held and frozen until bready
	b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(b))
		else begin
			$error("write response dropped or changed before its handshake");
			fail_cnt++;
		end

	// no new address while a response is pending
	ar_block: assert property (@(posedge clk) disable iff (rst)
		rvalid |-> !arready)
		else begin
			$error("arready high while rvalid is pending");
			fail_cnt++;
		end

	// reset clears both response paths
	rst_clear: assert property (@(posedge clk) rst |=> !rvalid && !bvalid)
		else begin
			$error("response valid high right after reset");
			fail_cnt++;
		end

endmodule

/* tb/mem_subsys_tb.sv */
`timescale 1ns/1ps

module mem_subsys_tb;

	localparam int mem_words = 256;
	localparam int n_cycles = 4000;
	localparam int max_wait = 200;
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;

	// expected read response, data unchecked for never-written words
	typedef struct packed {
		logic                           chk_data;
		logic [axi_mem_pkg::data_w-1:0] data;
		axi_mem_pkg::resp_t             resp;
	} exp_t;

	logic clk;
	logic rst;

	// read ports, index 0 fetch, 1 load/store
	logic                 arvalid [2];
	axi_mem_pkg::ar_req_t ar [2];
	logic                 arready [2];
	logic                 rvalid [2];
	axi_mem_pkg::r_rsp_t  r [2];
	logic                 rready [2];

	logic                 awvalid;
	axi_mem_pkg::aw_req_t aw;
	logic                 awready;
	logic                 wvalid;
	axi_mem_pkg::w_req_t  w;
	logic                 wready;
	logic                 bvalid;
	axi_mem_pkg::b_rsp_t  b;
	logic                 bready;

	// reference memory, written flag means every byte is known
	logic [63:0] model_mem [mem_words];
	logic        written [mem_words];
	exp_t        if_q [$];
	exp_t        ls_q [$];
	logic [31:0] lfsr;

	// per-port read tracking
	logic                rd_due [2];
	logic                rd_stall [2];
	logic                ar_acc [2];
	axi_mem_pkg::r_rsp_t r_prev [2];
	int                  ar_age [2];
	int                  r_age [2];

	// round robin history
	logic                last_gnt_ls;
	logic                gnt_seen;

	// write tracking
	logic               b_pend;
	logic               b_due;
	logic               b_stall;
	logic               w_acc;
	axi_mem_pkg::resp_t b_exp;
	axi_mem_pkg::resp_t b_prev;
	int                 aw_age;
	int                 b_age;

	tb_clock_gen #(.RST_CYCLES (10)) clk_gen_i (.clk (clk), .rst (rst));

	mem_subsys_top #(
		.MEM_WORDS (mem_words)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.if_arvalid (arvalid[0]),
		.if_ar      (ar[0]),
		.if_arready (arready[0]),
		.if_rvalid  (rvalid[0]),
		.if_r       (r[0]),
		.if_rready  (rready[0]),
		.ls_arvalid (arvalid[1]),
		.ls_ar      (ar[1]),
		.ls_arready (arready[1]),
		.ls_rvalid  (rvalid[1]),
		.ls_r       (r[1]),
		.ls_rready  (rready[1]),
		.ls_awvalid (awvalid),
		.ls_aw      (aw),
		.ls_awready (awready),
		.ls_wvalid  (wvalid),
		.ls_w       (w),
		.ls_wready  (wready),
		.ls_bvalid  (bvalid),
		.ls_b       (b),
		.ls_bready  (bready)
	);

	// handshake properties on the slave
	bind sram_axi_slave mem_subsys_props props_i (
		.clk     (clk),
		.rst     (rst),
		.arready (arready),
		.rvalid  (rvalid),
		.rready  (rready),
		.r       (r),
		.bvalid  (bvalid),
		.bready  (bready),
		.b       (b)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
		if (act !== exp) begin
			fail_run($sformatf("FAILED time=%0t signal=%s actual=0x%0h expected=0x%0h",
				$time, name, act, exp));
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	// small hot range so reads hit written words
	// one in eight lands past the end
	function automatic logic [31:0] rand_addr();
		logic [28:0] word;
		logic [2:0]  lane;
		if (rand_bits(3) == 0) word = 29'(mem_words) + 29'(rand_bits(6));
		else word = 29'(rand_bits(5));
		lane = 3'(rand_bits(3));
		return {word, lane};
	endfunction

	function automatic string port_name(input int p);
		return p ? "ls" : "if";
	endfunction

	function automatic int q_size(input int p);
		return p ? ls_q.size() : if_q.size();
	endfunction

	function automatic exp_t q_front(input int p);
		return p ? ls_q[0] : if_q[0];
	endfunction

	function automatic void q_push(input int p, input exp_t e);
		if (p) ls_q.push_back(e);
		else if_q.push_back(e);
	endfunction

	function automatic void q_pop(input int p);
		if (p) ls_q.pop_front();
		else if_q.pop_front();
	endfunction

	// what the memory holds right now for this address
	function automatic exp_t read_model(input logic [31:0] addr);
		exp_t        e;
		logic [28:0] word;
		word = addr[31:3];
		e.chk_data = 1'b1;
		e.data = '0;
		e.resp = axi_mem_pkg::resp_decerr;
		if (word < mem_words) begin
			e.chk_data = written[word];
			e.data = model_mem[word];
			e.resp = axi_mem_pkg::resp_okay;
		end
		return e;
	endfunction

	// strobed merge, out-of-range writes dropped
	function automatic void write_model(input logic [31:0] addr, input axi_mem_pkg::w_req_t wd);
		logic [28:0] word;
		word = addr[31:3];
		if (word < mem_words) begin
			for (int i = 0; i < 8; i++) begin
				if (wd.strb[i]) model_mem[word][i*8 +: 8] = wd.data[i*8 +: 8];
			end
			written[word] = 1'b1;
		end
	endfunction

	task automatic sample_reads();
		exp_t e;
		logic rd_busy;
		logic contend;
		logic exp_rdy;
		// one read outstanding at a time, the port not granted last wins
		rd_busy = (if_q.size() != 0) || (ls_q.size() != 0);
		contend = arvalid[0] && arvalid[1] && !rd_busy;
		// no grant yet, either may win but never both
		if (contend && !gnt_seen) begin
			check("if_arready^ls_arready", arready[0] ^ arready[1], 1'b1);
		end
		for (int p = 0; p < 2; p++) begin
			exp_rdy = !rd_busy && (!arvalid[1-p] || (last_gnt_ls != (p == 1)));
			if (arvalid[p] && !(contend && !gnt_seen)) begin
				check({port_name(p), "_arready"}, arready[p], exp_rdy);
			end
		end
		for (int p = 0; p < 2; p++) begin
			// accepted last cycle, response due now
			if (rd_due[p]) check({port_name(p), "_rvalid"}, rvalid[p], 1'b1);
			if (rd_stall[p]) begin
				check({port_name(p), "_rvalid"}, rvalid[p], 1'b1);
				check({port_name(p), "_r.data"}, r[p].data, r_prev[p].data);
				check({port_name(p), "_r.resp"}, r[p].resp, r_prev[p].resp);
			end
			if (rvalid[p]) begin
				if (q_size(p) == 0) begin
					fail_run({port_name(p), " port got a read response with no request outstanding"});
				end
				e = q_front(p);
				check({port_name(p), "_r.resp"}, r[p].resp, e.resp);
				if (e.chk_data) check({port_name(p), "_r.data"}, r[p].data, e.data);
				if (rready[p]) q_pop(p);
			end
			rd_stall[p] = rvalid[p] && !rready[p];
			r_prev[p] = r[p];
			r_age[p] = (q_size(p) == 0) ? 0 : r_age[p] + 1;
			// read sees memory before a same-edge write
			ar_acc[p] = arvalid[p] && arready[p];
			rd_due[p] = ar_acc[p];
			if (ar_acc[p]) begin
				q_push(p, read_model(ar[p].addr));
				last_gnt_ls = (p == 1);
				gnt_seen = 1'b1;
			end
			ar_age[p] = (arvalid[p] && !ar_acc[p]) ? ar_age[p] + 1 : 0;
			if (ar_age[p] > max_wait) fail_run({port_name(p), " read address was never accepted"});
			if (r_age[p] > max_wait) fail_run({port_name(p), " read response never arrived"});
		end
	endtask

	task automatic sample_write();
		// address and data taken together, only while no response is pending
		check("ls_awready", awready, awvalid && wvalid && !b_pend);
		check("ls_wready", wready, awvalid && wvalid && !b_pend);
		if (b_due) check("ls_bvalid", bvalid, 1'b1);
		if (b_stall) begin
			check("ls_bvalid", bvalid, 1'b1);
			check("ls_b.resp", b.resp, b_prev);
		end
		if (bvalid) begin
			if (!b_pend) fail_run("write response seen with no write outstanding");
			check("ls_b.resp", b.resp, b_exp);
			if (bready) b_pend = 1'b0;
		end
		b_stall = bvalid && !bready;
		b_prev = b.resp;
		b_age = b_pend ? b_age + 1 : 0;
		w_acc = awvalid && awready && wvalid && wready;
		b_due = w_acc;
		if (w_acc) begin
			b_exp = (aw.addr[31:3] < mem_words) ? axi_mem_pkg::resp_okay
				: axi_mem_pkg::resp_decerr;
			write_model(aw.addr, w);
			b_pend = 1'b1;
		end
		aw_age = (awvalid && !w_acc) ? aw_age + 1 : 0;
		if (aw_age > max_wait) fail_run("write address and data were never accepted");
		if (b_age > max_wait) fail_run("write response never arrived");
	endtask

	// new request only once the previous one is taken
	task automatic drive_inputs(input logic issue);
		logic [31:0] addr;
		logic [28:0] word;
		for (int p = 0; p < 2; p++) begin
			if (!arvalid[p] || ar_acc[p]) begin
				arvalid[p] = issue && (rand_bits(2) == 0);
				ar[p].addr = rand_addr();
			end
			rready[p] = (rand_bits(2) != 0);
		end
		if (!awvalid || w_acc) begin
			addr = rand_addr();
			word = addr[31:3];
			awvalid = issue && (rand_bits(2) == 0);
			wvalid = awvalid;
			aw.addr = addr;
			w.data = rand_bits(64);
			w.strb = 8'(rand_bits(8));
			// first write to a word fills every byte
			if (word < mem_words && !written[word]) w.strb = '1;
		end
		bready = (rand_bits(2) != 0);
	endtask

	function automatic logic busy();
		return arvalid[0] || arvalid[1] || awvalid || b_pend || (if_q.size() != 0)
			|| (ls_q.size() != 0);
	endfunction

	initial begin
		int cyc;
		int n;
		lfsr = 32'd60;
		for (int p = 0; p < 2; p++) begin
			arvalid[p] = 1'b0;
			ar[p] = '0;
			rready[p] = 1'b0;
			rd_due[p] = 1'b0;
			rd_stall[p] = 1'b0;
			ar_acc[p] = 1'b0;
			ar_age[p] = 0;
			r_age[p] = 0;
		end
		last_gnt_ls = 1'b0;
		gnt_seen = 1'b0;
		awvalid = 1'b0;
		aw = '0;
		wvalid = 1'b0;
		w = '0;
		bready = 1'b0;
		{b_pend, b_due, b_stall, w_acc} = '0;
		aw_age = 0;
		b_age = 0;
		for (int i = 0; i < mem_words; i++) written[i] = 1'b0;
		// responses stay quiet through reset
		@(negedge clk);
		n = 0;
		while (rst) begin
			check("if_rvalid", rvalid[0], 1'b0);
			check("ls_rvalid", rvalid[1], 1'b0);
			check("ls_bvalid", bvalid, 1'b0);
			n++;
			if (n > 50) fail_run("reset was never released");
			@(negedge clk);
		end
		// sample at the falling edge, drive 1 ns after the rising edge
		cyc = 0;
		while (cyc < n_cycles || busy()) begin
			if (dut_i.sram_i.props_i.fail_cnt != 0) begin
				fail_run("a handshake assertion in the slave failed");
			end
			sample_reads();
			sample_write();
			if (cyc > n_cycles + max_wait) fail_run("traffic did not drain after the last request");
			@(posedge clk);
			#1;
			drive_inputs(cyc < n_cycles);
			@(negedge clk);
			cyc++;
		end
		if (dut_i.sram_i.props_i.fail_cnt != 0) begin
			fail_run("a handshake assertion in the slave failed");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int RST_CYCLES = 10
) (
	output logic clk,
	output logic rst
);

	// 20 ns period, first rising edge at 10 ns
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset seen by the first RST_CYCLES rising edges
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

/* verilog/axi_mem_pkg.sv */
package axi_mem_pkg;

	// byte address width seen on both address channels
	localparam int addr_w = 32;

	// one full rv64 word per beat
	localparam int data_w = 64;

	// one strobe bit per data byte
	localparam int strb_w = data_w / 8;

	// response code carried on r and b
	typedef logic [1:0] resp_t;

	// normal completion
	localparam resp_t resp_okay = 2'd0;

	// address outside the memory
	localparam resp_t resp_decerr = 2'd3;

	// read address channel payload
	typedef struct packed {
		logic [addr_w-1:0] addr;
	} ar_req_t;

	// write address channel payload
	typedef struct packed {
		logic [addr_w-1:0] addr;
	} aw_req_t;

	// write data channel payload
	// strb bit i enables data byte i
	typedef struct packed {
		logic [data_w-1:0] data;
		logic [strb_w-1:0] strb;
	} w_req_t;

	// read data channel payload
	// data is zero on decerr
	typedef struct packed {
		logic [data_w-1:0] data;
		resp_t             resp;
	} r_rsp_t;

	// write response channel payload
	typedef struct packed {
		resp_t resp;
	} b_rsp_t;

endpackage

/* verilog/axi_read_arbiter.sv */
`timescale 1ns/1ps

module axi_read_arbiter (
	input  logic                 clk,
	input  logic                 rst,

	// fetch read port
	input  logic                 if_arvalid,
	input  axi_mem_pkg::ar_req_t if_ar,
	output logic                 if_arready,
	output logic                 if_rvalid,
	output axi_mem_pkg::r_rsp_t  if_r,
	input  logic                 if_rready,

	// load/store read port
	input  logic                 ls_arvalid,
	input  axi_mem_pkg::ar_req_t ls_ar,
	output logic                 ls_arready,
	output logic                 ls_rvalid,
	output axi_mem_pkg::r_rsp_t  ls_r,
	input  logic                 ls_rready,

	// towards the slave
	output logic                 arvalid,
	output axi_mem_pkg::ar_req_t ar,
	input  logic                 arready,
	input  logic                 rvalid,
	input  axi_mem_pkg::r_rsp_t  r,
	output logic                 rready
);

	// who currently holds the slave read path
	typedef enum logic [1:0] {
		own_idle,
		own_if,
		own_ls
	} owner_t;

	owner_t owner;

	// set when load/store got the last grant
	logic last_ls;

	// load/store selected for the next grant
	logic sel_ls;
	logic idle;
	logic ar_hs;
	logic r_hs;

	assign idle = (owner == own_idle);

	// round robin, a lone requester always wins
	// with both valid, the one not granted last goes first
	assign sel_ls = ls_arvalid && (!if_arvalid || !last_ls);

	// address path is combinational, no extra cycle
	assign arvalid = idle && (if_arvalid || ls_arvalid);
	assign ar      = sel_ls ? ls_ar : if_ar;

	// ready only to the selected requester
	// the other one sees ready low until its turn
	assign if_arready = idle && !sel_ls && arready;
	assign ls_arready = idle && sel_ls && arready;

	assign ar_hs = arvalid && arready;

	// response goes to the owner only
	assign if_rvalid = (owner == own_if) && rvalid;
	assign ls_rvalid = (owner == own_ls) && rvalid;

	// payload shared, qualified by each port's rvalid
	assign if_r = r;
	assign ls_r = r;

	always_comb begin
		case (owner)
			own_if:  rready = if_rready;
			own_ls:  rready = ls_rready;
			default: rready = 1'b0;
		endcase
	end

	assign r_hs = rvalid && rready;

	// ownership locks on address accept, frees on response accept
	always_ff @(posedge clk) begin
		if (rst) begin
			owner   <= own_idle;
			last_ls <= 1'b0;
		end else begin
			case (owner)
				own_idle: begin
					if (ar_hs) begin
						owner   <= sel_ls ? own_ls : own_if;
						last_ls <= sel_ls;
					end
				end
				own_if, own_ls: begin
					// back to idle, next grant possible the cycle after
					if (r_hs) owner <= own_idle;
				end
				default: owner <= own_idle;
			endcase
		end
	end

endmodule

/* verilog/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top #(
	parameter int MEM_WORDS = 256
) (
	input  logic                 clk,
	input  logic                 rst,

	// fetch read port
	input  logic                 if_arvalid,
	input  axi_mem_pkg::ar_req_t if_ar,
	output logic                 if_arready,
	output logic                 if_rvalid,
	output axi_mem_pkg::r_rsp_t  if_r,
	input  logic                 if_rready,

	// load/store read port
	input  logic                 ls_arvalid,
	input  axi_mem_pkg::ar_req_t ls_ar,
	output logic                 ls_arready,
	output logic                 ls_rvalid,
	output axi_mem_pkg::r_rsp_t  ls_r,
	input  logic                 ls_rready,

	// load/store write port, straight to the slave
	input  logic                 ls_awvalid,
	input  axi_mem_pkg::aw_req_t ls_aw,
	output logic                 ls_awready,
	input  logic                 ls_wvalid,
	input  axi_mem_pkg::w_req_t  ls_w,
	output logic                 ls_wready,
	output logic                 ls_bvalid,
	output axi_mem_pkg::b_rsp_t  ls_b,
	input  logic                 ls_bready
);

	// arbiter to slave read channels
	logic                 arvalid;
	axi_mem_pkg::ar_req_t ar;
	logic                 arready;
	logic                 rvalid;
	axi_mem_pkg::r_rsp_t  r;
	logic                 rready;

	// two read requesters share one slave read path
	axi_read_arbiter arb_i (
		.clk        (clk),
		.rst        (rst),
		.if_arvalid (if_arvalid),
		.if_ar      (if_ar),
		.if_arready (if_arready),
		.if_rvalid  (if_rvalid),
		.if_r       (if_r),
		.if_rready  (if_rready),
		.ls_arvalid (ls_arvalid),
		.ls_ar      (ls_ar),
		.ls_arready (ls_arready),
		.ls_rvalid  (ls_rvalid),
		.ls_r       (ls_r),
		.ls_rready  (ls_rready),
		.arvalid    (arvalid),
		.ar         (ar),
		.arready    (arready),
		.rvalid     (rvalid),
		.r          (r),
		.rready     (rready)
	);

	// writes bypass the arbiter
	sram_axi_slave #(
		.MEM_WORDS (MEM_WORDS)
	) sram_i (
		.clk     (clk),
		.rst     (rst),
		.arvalid (arvalid),
		.ar      (ar),
		.arready (arready),
		.rvalid  (rvalid),
		.r       (r),
		.rready  (rready),
		.awvalid (ls_awvalid),
		.aw      (ls_aw),
		.awready (ls_awready),
		.wvalid  (ls_wvalid),
		.w       (ls_w),
		.wready  (ls_wready),
		.bvalid  (ls_bvalid),
		.b       (ls_b),
		.bready  (ls_bready)
	);

endmodule

/* verilog/sram_axi_slave.sv */
`timescale 1ns/1ps

module sram_axi_slave #(
	parameter int MEM_WORDS = 256
) (
	input  logic                 clk,
	input  logic                 rst,

	// read address channel
	input  logic                 arvalid,
	input  axi_mem_pkg::ar_req_t ar,
	output logic                 arready,

	// read data channel
	output logic                 rvalid,
	output axi_mem_pkg::r_rsp_t  r,
	input  logic                 rready,

	// write address channel
	input  logic                 awvalid,
	input  axi_mem_pkg::aw_req_t aw,
	output logic                 awready,

	// write data channel
	input  logic                 wvalid,
	input  axi_mem_pkg::w_req_t  w,
	output logic                 wready,

	// write response channel
	output logic                 bvalid,
	output axi_mem_pkg::b_rsp_t  b,
	input  logic                 bready
);

	// index bits actually used to address the array
	localparam int idx_w = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	// byte address with the three byte-lane bits dropped
	localparam int word_w = axi_mem_pkg::addr_w - 3;

	typedef enum logic {
		rd_idle,
		rd_resp
	} rd_state_t;

	typedef enum logic {
		wr_idle,
		wr_resp
	} wr_state_t;

	rd_state_t rd_state;
	wr_state_t wr_state;

	// storage, one 64-bit word per entry
	logic [axi_mem_pkg::data_w-1:0] mem [MEM_WORDS];

	logic [word_w-1:0] rd_word;
	logic [word_w-1:0] wr_word;
	logic [idx_w-1:0]  rd_idx;
	logic [idx_w-1:0]  wr_idx;
	logic              rd_in_range;
	logic              wr_in_range;
	logic              ar_hs;
	logic              r_hs;
	logic              w_hs;
	logic              b_hs;

	// word number = byte address / 8
	assign rd_word = ar.addr[axi_mem_pkg::addr_w-1:3];
	assign wr_word = aw.addr[axi_mem_pkg::addr_w-1:3];
	assign rd_idx  = rd_word[idx_w-1:0];
	assign wr_idx  = wr_word[idx_w-1:0];

	// anything at or past MEM_WORDS is a decode error
	assign rd_in_range = (rd_word < MEM_WORDS);
	assign wr_in_range = (wr_word < MEM_WORDS);

	// address only taken while no response is pending
	assign arready = (rd_state == rd_idle);
	assign rvalid  = (rd_state == rd_resp);

	// address and data go in together, never one without the other
	assign awready = (wr_state == wr_idle) && awvalid && wvalid;
	assign wready  = (wr_state == wr_idle) && awvalid && wvalid;
	assign bvalid  = (wr_state == wr_resp);

	assign ar_hs = arvalid && arready;
	assign r_hs  = rvalid && rready;
	assign w_hs  = awvalid && awready && wvalid && wready;
	assign b_hs  = bvalid && bready;

	// read fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= rd_idle;
		end else begin
			case (rd_state)
				rd_idle: if (ar_hs) rd_state <= rd_resp;
				// hold the response until the master takes it
				rd_resp: if (r_hs) rd_state <= rd_idle;
				default: rd_state <= rd_idle;
			endcase
		end
	end

	// read response captured on acceptance, held while rvalid
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			if (rd_in_range) begin
				r.data <= mem[rd_idx];
				r.resp <= axi_mem_pkg::resp_okay;
			end else begin
				r.data <= '0;
				r.resp <= axi_mem_pkg::resp_decerr;
			end
		end
	end

	// write fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= wr_idle;
		end else begin
			case (wr_state)
				wr_idle: if (w_hs) wr_state <= wr_resp;
				wr_resp: if (b_hs) wr_state <= wr_idle;
				default: wr_state <= wr_idle;
			endcase
		end
	end

	// strobed byte update, out-of-range writes dropped
	always_ff @(posedge clk) begin
		if (w_hs && wr_in_range) begin
			for (int i = 0; i < axi_mem_pkg::strb_w; i++) begin
				if (w.strb[i]) mem[wr_idx][i*8 +: 8] <= w.data[i*8 +: 8];
			end
		end
	end

	// write response code
	always_ff @(posedge clk) begin
		if (w_hs) begin
			b.resp <= wr_in_range ? axi_mem_pkg::resp_okay : axi_mem_pkg::resp_decerr;
		end
	end

endmodule
